//--- x68k_ctrl_pkg.sv
// control-side types for the X68000 glue logic
// divider periods, media slot counts, strobe and request structs, loader states

package x68k_ctrl_pkg;

	////////////////////////////////////////////////////////////
	// divider periods, in clk_sys cycles

	localparam int SYS_DIV      = 4;
	localparam int SND_DIV_FAST = 5;
	// also the period of opm strobe 0
	localparam int SND_DIV_SLOW = 10;
	localparam int OPM_DIV      = 20;

	////////////////////////////////////////////////////////////
	// media slots: 0 and 1 floppy, 2 hard disk, 3 sram

	localparam int NUM_MEDIA = 4;
	localparam int NUM_FDD   = 2;

	typedef struct packed {
		logic       sys_ce;
		logic       mpu_cep;
		logic       mpu_cen;
		logic       snd_ce;
		logic [1:0] opm_ce;
	} clk_en_t;

	typedef struct packed {
		logic               reset_req;
		logic               reset_button;
		logic               turbo;
		logic               snd_slow;
		logic [NUM_FDD-1:0] fdd_eject;
	} host_ctrl_t;

	typedef struct packed {
		logic [NUM_MEDIA-1:0] mounted;
		logic [NUM_FDD-1:0]   fdd_ejecting;
	} media_state_t;

	// one host download byte
	typedef struct packed {
		logic [19:0] addr;
		logic [7:0]  data;
	} ldr_req_t;

	typedef enum logic [1:0] {
		LDR_IDLE,
		LDR_WRITE,
		LDR_DONE
	} ldr_state_t;

endpackage

//--- x68k_audio_pkg.sv
// audio-side types for the glue logic
// sample and stereo types, compressor modes and curve constants

package x68k_audio_pkg;

	typedef logic signed [15:0] sample_t;

	typedef struct packed {
		sample_t left;
		sample_t right;
	} stereo_t;

	typedef enum logic [1:0] {
		COMP_OFF,
		COMP_LIGHT,
		COMP_HEAVY
	} comp_mode_t;

	////////////////////////////////////////////////////////////
	// curve constants
	// F is the slope divider above the knee, A the gain below it

	localparam int COMP_LIGHT_F = 4;
	localparam int COMP_LIGHT_A = 2;
	localparam int COMP_HEAVY_F = 8;
	localparam int COMP_HEAVY_A = 4;

	// knee = 32767*(F-1)/(F*A-1) + 1, so that full scale maps near full scale
	localparam int COMP_LIGHT_KNEE =
		(32767 * (COMP_LIGHT_F - 1)) / (COMP_LIGHT_F * COMP_LIGHT_A - 1) + 1;
	localparam int COMP_HEAVY_KNEE =
		(32767 * (COMP_HEAVY_F - 1)) / (COMP_HEAVY_F * COMP_HEAVY_A - 1) + 1;

	// largest magnitude a positive sample can hold
	localparam int COMP_MAG_MAX = 32767;

endpackage

//--- clk_enable_gen.sv
// clock-enable strobes for the core
// system, cpu phase, sound and opm dividers with turbo cpu mode

`timescale 1ns/1ps

module clk_enable_gen (
	input  logic                   clk_sys,
	input  logic                   reset_delayed,
	input  logic                   turbo_i,
	input  logic                   snd_slow_i,
	output x68k_ctrl_pkg::clk_en_t clk_en_o
);

	localparam int SYS_W  = $clog2(x68k_ctrl_pkg::SYS_DIV);
	localparam int FAST_W = $clog2(x68k_ctrl_pkg::SND_DIV_FAST);
	localparam int SLOW_W = $clog2(x68k_ctrl_pkg::SND_DIV_SLOW);
	localparam int OPM_W  = $clog2(x68k_ctrl_pkg::OPM_DIV);

	localparam logic [SYS_W-1:0]  SYS_LAST  = SYS_W'(x68k_ctrl_pkg::SYS_DIV - 1);
	// normal mode cen phase, half a window before cep
	localparam logic [SYS_W-1:0]  SYS_HALF  = SYS_W'(x68k_ctrl_pkg::SYS_DIV / 2 - 1);
	localparam logic [FAST_W-1:0] FAST_LAST = FAST_W'(x68k_ctrl_pkg::SND_DIV_FAST - 1);
	localparam logic [SLOW_W-1:0] SLOW_LAST = SLOW_W'(x68k_ctrl_pkg::SND_DIV_SLOW - 1);
	localparam logic [OPM_W-1:0]  OPM_LAST  = OPM_W'(x68k_ctrl_pkg::OPM_DIV - 1);

	logic [SYS_W-1:0]  div_sys;
	logic [FAST_W-1:0] div_fast;
	logic [SLOW_W-1:0] div_slow;
	logic [OPM_W-1:0]  div_opm;
	logic              turbo_q;
	logic              sys_end;
	logic              fast_end;
	logic              slow_end;
	logic              opm_end;

	assign sys_end  = (div_sys == SYS_LAST);
	assign fast_end = (div_fast == FAST_LAST);
	assign slow_end = (div_slow == SLOW_LAST);
	assign opm_end  = (div_opm == OPM_LAST);

	////////////////////////////////////////////////////////////
	// divider counters, each wrapping at its own count

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			div_sys  <= '0;
			div_fast <= '0;
			div_slow <= '0;
			div_opm  <= '0;
		end else begin
			div_sys  <= sys_end  ? '0 : div_sys + 1'b1;
			div_fast <= fast_end ? '0 : div_fast + 1'b1;
			div_slow <= slow_end ? '0 : div_slow + 1'b1;
			div_opm  <= opm_end  ? '0 : div_opm + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// registered strobes

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			turbo_q  <= 1'b0;
			clk_en_o <= '0;
		end else begin
			// turbo only changes on a window boundary
			if (sys_end)
				turbo_q <= turbo_i;
			clk_en_o.sys_ce    <= sys_end;
			// turbo alternates the phases every cycle
			clk_en_o.mpu_cep   <= turbo_q ? div_sys[0] : sys_end;
			clk_en_o.mpu_cen   <= turbo_q ? ~div_sys[0] : (div_sys == SYS_HALF);
			clk_en_o.snd_ce    <= snd_slow_i ? slow_end : fast_end;
			clk_en_o.opm_ce[0] <= slow_end;
			clk_en_o.opm_ce[1] <= opm_end;
		end
	end

endmodule

//--- media_reset_seq.sv
// media mount and eject hold counters
// hard-disk reset hold and the combined core run level

`timescale 1ns/1ps

module media_reset_seq #(
	parameter int MOUNT_HOLD_W = 24,
	parameter int EJECT_HOLD_W = 16,
	parameter int HDD_RESET_W  = 16
) (
	input  logic                                  clk_sys,
	input  logic                                  reset_delayed,
	input  x68k_ctrl_pkg::host_ctrl_t             host_i,
	input  logic [x68k_ctrl_pkg::NUM_MEDIA-1:0]   img_mounted_i,
	input  logic                                  ioctl_download_i,
	output x68k_ctrl_pkg::media_state_t           media_o,
	output logic                                  core_run_o
);

	localparam int NUM_MEDIA = x68k_ctrl_pkg::NUM_MEDIA;
	localparam int NUM_FDD   = x68k_ctrl_pkg::NUM_FDD;
	localparam int HDD_SLOT  = 2;
	// top third of the mount count marks the eject phase of a re-mount
	localparam int THIRD_W   = MOUNT_HOLD_W / 3;

	logic [MOUNT_HOLD_W-1:0] mount_cnt [NUM_MEDIA];
	logic [EJECT_HOLD_W-1:0] eject_cnt [NUM_FDD];
	logic [HDD_RESET_W-1:0]  hdd_cnt;

	logic [NUM_FDD-1:0] eject_q;
	logic [NUM_FDD-1:0] eject_rise;
	logic               download_q;
	logic               reset_req_q;
	logic               download_seen;
	logic               init_done;
	logic               reset_int;

	assign eject_rise = host_i.fdd_eject & ~eject_q;

	////////////////////////////////////////////////////////////
	// hold counters

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			for (int x = 0; x < NUM_MEDIA; x++)
				mount_cnt[x] <= '0;
			for (int x = 0; x < NUM_FDD; x++)
				eject_cnt[x] <= '0;
			hdd_cnt <= '0;
		end else begin
			for (int x = 0; x < NUM_MEDIA; x++) begin
				if (img_mounted_i[x])
					mount_cnt[x] <= '1;
				else if (|mount_cnt[x])
					mount_cnt[x] <= mount_cnt[x] - 1'b1;
			end
			for (int x = 0; x < NUM_FDD; x++) begin
				if (eject_rise[x])
					eject_cnt[x] <= '1;
				else if (|eject_cnt[x])
					eject_cnt[x] <= eject_cnt[x] - 1'b1;
			end
			// hard-disk mount keeps the core in reset for a while
			if (img_mounted_i[HDD_SLOT])
				hdd_cnt <= '1;
			else if (|hdd_cnt)
				hdd_cnt <= hdd_cnt - 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// edge detection and reset combination

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			eject_q       <= '0;
			download_q    <= 1'b0;
			reset_req_q   <= 1'b0;
			download_seen <= 1'b0;
			init_done     <= 1'b0;
			reset_int     <= 1'b1;
		end else begin
			eject_q     <= host_i.fdd_eject;
			download_q  <= ioctl_download_i;
			reset_req_q <= host_i.reset_req;
			if (ioctl_download_i && !download_q)
				download_seen <= 1'b1;
			// first release of the host reset lets the core run
			if (reset_req_q && !host_i.reset_req)
				init_done <= 1'b1;
			reset_int <= host_i.reset_button || host_i.reset_req ||
				(|hdd_cnt) || !init_done;
		end
	end

	assign core_run_o = download_seen && !reset_int;

	// held media levels
	always_comb begin
		media_o = '0;
		for (int x = 0; x < NUM_FDD; x++) begin
			media_o.fdd_ejecting[x] = (|mount_cnt[x][MOUNT_HOLD_W-1 -: THIRD_W]) ||
				(|eject_cnt[x]);
			media_o.mounted[x] = (|mount_cnt[x]) && !media_o.fdd_ejecting[x];
		end
		for (int x = NUM_FDD; x < NUM_MEDIA; x++)
			media_o.mounted[x] = |mount_cnt[x];
	end

endmodule

//--- loader_fsm.sv
// loader write FSM
// turns host download writes into requests acknowledged by the core

`timescale 1ns/1ps

module loader_fsm (
	input  logic                    clk_sys,
	input  logic                    reset_delayed,
	input  logic                    ioctl_download_i,
	input  logic                    ioctl_wr_i,
	input  x68k_ctrl_pkg::ldr_req_t ioctl_req_i,
	input  logic                    ldr_ack_i,
	output logic                    ldr_wr_o,
	output logic                    ldr_aen_o,
	output logic                    ldr_done_o,
	output x68k_ctrl_pkg::ldr_req_t ldr_req_o
);

	x68k_ctrl_pkg::ldr_state_t state;
	x68k_ctrl_pkg::ldr_state_t state_d;

	logic ack_q;
	logic download_q;
	logic ack_rise;
	logic download_fall;
	logic wr_accept;

	assign ack_rise      = ldr_ack_i && !ack_q;
	assign download_fall = download_q && !ioctl_download_i;
	// writes after the end of download are dropped
	assign wr_accept     = ioctl_wr_i && (state != x68k_ctrl_pkg::LDR_DONE);

	always_comb begin
		state_d = state;
		case (state)
			x68k_ctrl_pkg::LDR_IDLE:
				if (wr_accept)
					state_d = x68k_ctrl_pkg::LDR_WRITE;
			x68k_ctrl_pkg::LDR_WRITE:
				// a new write beats an ack in the same cycle
				if (!wr_accept && ack_rise)
					state_d = x68k_ctrl_pkg::LDR_IDLE;
			default:
				state_d = state;
		endcase
		if (download_fall)
			state_d = x68k_ctrl_pkg::LDR_DONE;
	end

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			state      <= x68k_ctrl_pkg::LDR_IDLE;
			ack_q      <= 1'b0;
			download_q <= 1'b0;
			ldr_wr_o   <= 1'b0;
			ldr_aen_o  <= 1'b0;
			ldr_req_o  <= '0;
		end else begin
			state      <= state_d;
			ack_q      <= ldr_ack_i;
			download_q <= ioctl_download_i;
			ldr_aen_o  <= ioctl_download_i && (state != x68k_ctrl_pkg::LDR_DONE);
			// no waiting for a free slot, pending request is overwritten
			if (wr_accept) begin
				ldr_req_o <= ioctl_req_i;
				ldr_wr_o  <= 1'b1;
			end else if (ack_rise && ldr_wr_o) begin
				ldr_wr_o <= 1'b0;
			end
		end
	end

	assign ldr_done_o = (state == x68k_ctrl_pkg::LDR_DONE);

endmodule

//--- audio_compressor.sv
// stereo dynamic-range compressor
// two-stage pipeline with light and heavy curves

`timescale 1ns/1ps

module audio_compressor (
	input  logic                        clk_sys,
	input  logic                        reset_delayed,
	input  x68k_audio_pkg::stereo_t     audio_i,
	input  x68k_audio_pkg::comp_mode_t  comp_mode_i,
	output x68k_audio_pkg::stereo_t     audio_o
);

	// piecewise-linear curve on a magnitude, clipped at full scale
	function automatic logic [15:0] curve(
		input logic [15:0] mag,
		input int          knee,
		input int          f,
		input int          a
	);
		int m;
		int y;
		m = int'(mag);
		if (m < knee)
			y = m * a;
		else
			y = (m - knee) / f + knee * a;
		// the top of the curve overshoots full scale by a count or two
		if (y > x68k_audio_pkg::COMP_MAG_MAX)
			y = x68k_audio_pkg::COMP_MAG_MAX;
		return 16'(y);
	endfunction

	x68k_audio_pkg::sample_t    in_s [2];
	logic [15:0]                mag_d [2];
	logic [15:0]                mag_q [2];
	logic [1:0]                 neg_q;
	x68k_audio_pkg::comp_mode_t mode_q;
	x68k_audio_pkg::sample_t    res [2];

	////////////////////////////////////////////////////////////
	// stage 1: sign and magnitude

	always_comb begin
		in_s[0] = audio_i.left;
		in_s[1] = audio_i.right;
		for (int ch = 0; ch < 2; ch++)
			mag_d[ch] = in_s[ch][15] ? 16'(~in_s[ch] + 1'b1) : 16'(in_s[ch]);
	end

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			mag_q[0] <= '0;
			mag_q[1] <= '0;
			neg_q    <= '0;
			mode_q   <= x68k_audio_pkg::COMP_OFF;
		end else begin
			mag_q[0] <= mag_d[0];
			mag_q[1] <= mag_d[1];
			neg_q    <= {in_s[1][15], in_s[0][15]};
			mode_q   <= comp_mode_i;
		end
	end

	////////////////////////////////////////////////////////////
	// stage 2: curve and sign restore

	always_comb begin
		logic [15:0] mag_c;
		for (int ch = 0; ch < 2; ch++) begin
			case (mode_q)
				x68k_audio_pkg::COMP_LIGHT:
					mag_c = curve(mag_q[ch], x68k_audio_pkg::COMP_LIGHT_KNEE,
						x68k_audio_pkg::COMP_LIGHT_F, x68k_audio_pkg::COMP_LIGHT_A);
				x68k_audio_pkg::COMP_HEAVY:
					mag_c = curve(mag_q[ch], x68k_audio_pkg::COMP_HEAVY_KNEE,
						x68k_audio_pkg::COMP_HEAVY_F, x68k_audio_pkg::COMP_HEAVY_A);
				default:
					mag_c = mag_q[ch];
			endcase
			res[ch] = neg_q[ch] ? x68k_audio_pkg::sample_t'(~mag_c + 1'b1) :
				x68k_audio_pkg::sample_t'(mag_c);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			audio_o <= '0;
		end else begin
			audio_o.left  <= res[0];
			audio_o.right <= res[1];
		end
	end

endmodule

//--- x68k_glue_top.sv
// top level of the X68000 glue logic
// clock enables, media and reset sequencing, loader FSM and compressor

`timescale 1ns/1ps

module x68k_glue_top #(
	parameter int MOUNT_HOLD_W = 24,
	parameter int EJECT_HOLD_W = 16,
	parameter int HDD_RESET_W  = 16
) (
	input  logic                                clk_sys,
	input  logic                                reset_delayed,

	// host side
	input  x68k_ctrl_pkg::host_ctrl_t           host_i,
	input  logic [x68k_ctrl_pkg::NUM_MEDIA-1:0] img_mounted_i,
	input  logic                                ioctl_download_i,
	input  logic                                ioctl_wr_i,
	input  x68k_ctrl_pkg::ldr_req_t             ioctl_req_i,

	// core side
	input  logic                                ldr_ack_i,
	input  x68k_audio_pkg::stereo_t             audio_i,
	input  x68k_audio_pkg::comp_mode_t          comp_mode_i,

	output x68k_ctrl_pkg::clk_en_t              clk_en_o,
	output x68k_ctrl_pkg::media_state_t         media_o,
	output logic                                core_run_o,
	output logic                                ldr_wr_o,
	output logic                                ldr_aen_o,
	output logic                                ldr_done_o,
	output x68k_ctrl_pkg::ldr_req_t             ldr_req_o,
	output x68k_audio_pkg::stereo_t             audio_o
);

	////////////////////////////////////////////////////////////
	// clocking and reset

	clk_enable_gen i_clk_enable_gen (
		.clk_sys       (clk_sys),
		.reset_delayed (reset_delayed),
		.turbo_i       (host_i.turbo),
		.snd_slow_i    (host_i.snd_slow),
		.clk_en_o      (clk_en_o)
	);

	media_reset_seq #(
		.MOUNT_HOLD_W (MOUNT_HOLD_W),
		.EJECT_HOLD_W (EJECT_HOLD_W),
		.HDD_RESET_W  (HDD_RESET_W)
	) i_media_reset_seq (
		.clk_sys          (clk_sys),
		.reset_delayed    (reset_delayed),
		.host_i           (host_i),
		.img_mounted_i    (img_mounted_i),
		.ioctl_download_i (ioctl_download_i),
		.media_o          (media_o),
		.core_run_o       (core_run_o)
	);

	////////////////////////////////////////////////////////////
	// loader and audio

	loader_fsm i_loader_fsm (
		.clk_sys          (clk_sys),
		.reset_delayed    (reset_delayed),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_req_i      (ioctl_req_i),
		.ldr_ack_i        (ldr_ack_i),
		.ldr_wr_o         (ldr_wr_o),
		.ldr_aen_o        (ldr_aen_o),
		.ldr_done_o       (ldr_done_o),
		.ldr_req_o        (ldr_req_o)
	);

	audio_compressor i_audio_compressor (
		.clk_sys       (clk_sys),
		.reset_delayed (reset_delayed),
		.audio_i       (audio_i),
		.comp_mode_i   (comp_mode_i),
		.audio_o       (audio_o)
	);

endmodule

//--- tb_x68k_glue.sv
// testbench for the X68000 glue logic
// seeded random stimulus, cycle models of every block, typed compare tasks

`timescale 1ns/1ps

module tb_x68k_glue;

	localparam int MOUNT_W    = 9;
	localparam int EJECT_W    = 6;
	localparam int HDD_W      = 7;
	localparam int MOUNT_ONES = (1 << MOUNT_W) - 1;
	localparam int EJECT_ONES = (1 << EJECT_W) - 1;
	localparam int HDD_ONES   = (1 << HDD_W) - 1;
	localparam int SEED       = 32'h55e38fb9;

	localparam int RESET_CYCLES = 5;
	localparam int CLK_CYCLES   = 200;
	localparam int MOUNT_CYCLES = 1400;
	localparam int LOAD_CYCLES  = 300;
	localparam int DONE_CYCLES  = 40;
	localparam int RSEQ_CYCLES  = 700;
	localparam int AUDIO_CYCLES = 300;
	localparam int CYCLE_LIMIT  = RESET_CYCLES + CLK_CYCLES + MOUNT_CYCLES + LOAD_CYCLES +
		DONE_CYCLES + RSEQ_CYCLES + AUDIO_CYCLES + 100;

	// integer part of 32767*(F-1)/(F*A-1) plus one
	localparam int LIGHT_KNEE = (32767 * 3) / 7 + 1;
	localparam int HEAVY_KNEE = (32767 * 7) / 31 + 1;

	logic                                clk_sys = 1'b0;
	logic                                reset_delayed = 1'b1;
	logic                                h_reset_req = 1'b0;
	logic                                h_reset_button = 1'b0;
	logic                                h_turbo = 1'b0;
	logic                                h_snd_slow = 1'b0;
	logic [x68k_ctrl_pkg::NUM_FDD-1:0]   h_fdd_eject = '0;
	x68k_ctrl_pkg::host_ctrl_t           host_i;
	logic [x68k_ctrl_pkg::NUM_MEDIA-1:0] img_mounted_i = '0;
	logic                                ioctl_download_i = 1'b0;
	logic                                ioctl_wr_i = 1'b0;
	x68k_ctrl_pkg::ldr_req_t             ioctl_req_i = '0;
	logic                                ldr_ack_i = 1'b0;
	x68k_audio_pkg::stereo_t             audio_i = '0;
	x68k_audio_pkg::comp_mode_t          comp_mode_i = x68k_audio_pkg::COMP_OFF;

	x68k_ctrl_pkg::clk_en_t      clk_en_o;
	x68k_ctrl_pkg::media_state_t media_o;
	logic                        core_run_o;
	logic                        ldr_wr_o;
	logic                        ldr_aen_o;
	logic                        ldr_done_o;
	x68k_ctrl_pkg::ldr_req_t     ldr_req_o;
	x68k_audio_pkg::stereo_t     audio_o;

	// model state
	int                         c_sys;
	int                         c_fast;
	int                         c_slow;
	int                         c_opm;
	logic                       m_turbo;
	x68k_ctrl_pkg::clk_en_t     exp_ce;
	int                         m_mount [x68k_ctrl_pkg::NUM_MEDIA];
	int                         m_eject [x68k_ctrl_pkg::NUM_FDD];
	int                         m_hdd;
	logic [1:0]                 m_eject_q;
	logic                       m_dl_q;
	logic                       m_req_q;
	logic                       m_dl_seen;
	logic                       m_init_done;
	logic                       m_reset_int;
	x68k_ctrl_pkg::ldr_state_t  m_state;
	logic                       m_ack_q;
	logic                       m_ldl_q;
	logic                       m_wr;
	logic                       m_aen;
	x68k_ctrl_pkg::ldr_req_t    m_req;
	x68k_audio_pkg::stereo_t    m_a1;
	x68k_audio_pkg::comp_mode_t m_mode1;
	x68k_audio_pkg::stereo_t    exp_audio;

	logic        check_en = 1'b0;
	int          cycle_cnt = 0;
	int          ack_wait = 0;

	assign host_i = '{reset_req: h_reset_req, reset_button: h_reset_button, turbo: h_turbo,
		snd_slow: h_snd_slow, fdd_eject: h_fdd_eject};

	x68k_glue_top #(
		.MOUNT_HOLD_W (MOUNT_W),
		.EJECT_HOLD_W (EJECT_W),
		.HDD_RESET_W  (HDD_W)
	) i_x68k_glue_top (
		.clk_sys          (clk_sys),
		.reset_delayed    (reset_delayed),
		.host_i           (host_i),
		.img_mounted_i    (img_mounted_i),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_req_i      (ioctl_req_i),
		.ldr_ack_i        (ldr_ack_i),
		.audio_i          (audio_i),
		.comp_mode_i      (comp_mode_i),
		.clk_en_o         (clk_en_o),
		.media_o          (media_o),
		.core_run_o       (core_run_o),
		.ldr_wr_o         (ldr_wr_o),
		.ldr_aen_o        (ldr_aen_o),
		.ldr_done_o       (ldr_done_o),
		.ldr_req_o        (ldr_req_o),
		.audio_o          (audio_o)
	);

	always #4 clk_sys = ~clk_sys;

	////////////////////////////////////////////////////////////
	// compare tasks

	task automatic report_mismatch(input string sig, input string exp_s, input string act_s);
		$display("[FAIL] %0t ns: %s expected %s, got %s", $time, sig, exp_s, act_s);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check_clk_en(input x68k_ctrl_pkg::clk_en_t e,
		input x68k_ctrl_pkg::clk_en_t a);
		if (a !== e)
			report_mismatch("clk_en_o", $sformatf("%b", e), $sformatf("%b", a));
	endtask

	task automatic check_media(input x68k_ctrl_pkg::media_state_t e,
		input x68k_ctrl_pkg::media_state_t a);
		if (a !== e)
			report_mismatch("media_o", $sformatf("%b", e), $sformatf("%b", a));
	endtask

	task automatic check_run(input logic e, input logic a);
		if (a !== e)
			report_mismatch("core_run_o", $sformatf("%b", e), $sformatf("%b", a));
	endtask

	task automatic check_ldr(
		input x68k_ctrl_pkg::ldr_req_t e_req,
		input logic                    e_wr,
		input logic                    e_aen,
		input logic                    e_done,
		input x68k_ctrl_pkg::ldr_req_t a_req,
		input logic                    a_wr,
		input logic                    a_aen,
		input logic                    a_done
	);
		if (a_wr !== e_wr)
			report_mismatch("ldr_wr_o", $sformatf("%b", e_wr), $sformatf("%b", a_wr));
		if (a_aen !== e_aen)
			report_mismatch("ldr_aen_o", $sformatf("%b", e_aen), $sformatf("%b", a_aen));
		if (a_done !== e_done)
			report_mismatch("ldr_done_o", $sformatf("%b", e_done), $sformatf("%b", a_done));
		if (a_req !== e_req)
			report_mismatch("ldr_req_o", $sformatf("%h", e_req), $sformatf("%h", a_req));
	endtask

	task automatic check_audio(input x68k_audio_pkg::stereo_t e,
		input x68k_audio_pkg::stereo_t a);
		if (a !== e)
			report_mismatch("audio_o", $sformatf("%0d/%0d", e.left, e.right),
				$sformatf("%0d/%0d", a.left, a.right));
	endtask

	////////////////////////////////////////////////////////////
	// reference models

	function automatic int next_hold(input int v, input logic load, input int ones);
		if (load)
			return ones;
		return (v > 0) ? v - 1 : 0;
	endfunction

	function automatic x68k_audio_pkg::sample_t compress_sample(
		input x68k_audio_pkg::sample_t s, input x68k_audio_pkg::comp_mode_t mode);
		int mag;
		int knee;
		int f;
		int a;
		int y;
		mag = (s < 0) ? -int'(s) : int'(s);
		case (mode)
			x68k_audio_pkg::COMP_LIGHT: begin
				knee = LIGHT_KNEE;
				f = 4;
				a = 2;
			end
			x68k_audio_pkg::COMP_HEAVY: begin
				knee = HEAVY_KNEE;
				f = 8;
				a = 4;
			end
			default:
				return s;
		endcase
		y = (mag < knee) ? mag * a : (mag - knee) / f + knee * a;
		// saturates at positive full scale
		if (y > 32767)
			y = 32767;
		return (s < 0) ? 16'(-y) : 16'(y);
	endfunction

	function automatic x68k_ctrl_pkg::media_state_t media_expect();
		x68k_ctrl_pkg::media_state_t m;
		m = '0;
		for (int x = 0; x < x68k_ctrl_pkg::NUM_FDD; x++) begin
			m.fdd_ejecting[x] = ((m_mount[x] >> (MOUNT_W - MOUNT_W / 3)) != 0) ||
				(m_eject[x] != 0);
			m.mounted[x] = (m_mount[x] != 0) && !m.fdd_ejecting[x];
		end
		for (int x = x68k_ctrl_pkg::NUM_FDD; x < x68k_ctrl_pkg::NUM_MEDIA; x++)
			m.mounted[x] = (m_mount[x] != 0);
		return m;
	endfunction

	task automatic clear_models();
		c_sys = 0;
		c_fast = 0;
		c_slow = 0;
		c_opm = 0;
		m_turbo = 1'b0;
		exp_ce = '0;
		for (int x = 0; x < x68k_ctrl_pkg::NUM_MEDIA; x++)
			m_mount[x] = 0;
		for (int x = 0; x < x68k_ctrl_pkg::NUM_FDD; x++)
			m_eject[x] = 0;
		m_hdd = 0;
		m_eject_q = '0;
		m_dl_q = 1'b0;
		m_req_q = 1'b0;
		m_dl_seen = 1'b0;
		m_init_done = 1'b0;
		m_reset_int = 1'b1;
		m_state = x68k_ctrl_pkg::LDR_IDLE;
		m_ack_q = 1'b0;
		m_ldl_q = 1'b0;
		m_wr = 1'b0;
		m_aen = 1'b0;
		m_req = '0;
		m_a1 = '0;
		m_mode1 = x68k_audio_pkg::COMP_OFF;
		exp_audio = '0;
	endtask

	task automatic predict_strobes();
		logic sys_end;
		logic fast_end;
		logic slow_end;
		logic opm_end;
		sys_end  = (c_sys == x68k_ctrl_pkg::SYS_DIV - 1);
		fast_end = (c_fast == x68k_ctrl_pkg::SND_DIV_FAST - 1);
		slow_end = (c_slow == x68k_ctrl_pkg::SND_DIV_SLOW - 1);
		opm_end  = (c_opm == x68k_ctrl_pkg::OPM_DIV - 1);
		exp_ce.sys_ce  = sys_end;
		exp_ce.mpu_cep = m_turbo ? (c_sys % 2 == 1) : sys_end;
		// normal mode cen sits half a window ahead of cep
		exp_ce.mpu_cen = m_turbo ? (c_sys % 2 == 0) :
			(c_sys == x68k_ctrl_pkg::SYS_DIV / 2 - 1);
		exp_ce.snd_ce  = host_i.snd_slow ? slow_end : fast_end;
		exp_ce.opm_ce  = {opm_end, slow_end};
		if (sys_end)
			m_turbo = host_i.turbo;
		c_sys  = sys_end ? 0 : c_sys + 1;
		c_fast = fast_end ? 0 : c_fast + 1;
		c_slow = slow_end ? 0 : c_slow + 1;
		c_opm  = opm_end ? 0 : c_opm + 1;
	endtask

	task automatic update_media_holds();
		m_reset_int = host_i.reset_button || host_i.reset_req || (m_hdd != 0) || !m_init_done;
		if (ioctl_download_i && !m_dl_q)
			m_dl_seen = 1'b1;
		if (m_req_q && !host_i.reset_req)
			m_init_done = 1'b1;
		m_hdd = next_hold(m_hdd, img_mounted_i[2], HDD_ONES);
		for (int x = 0; x < x68k_ctrl_pkg::NUM_MEDIA; x++)
			m_mount[x] = next_hold(m_mount[x], img_mounted_i[x], MOUNT_ONES);
		for (int x = 0; x < x68k_ctrl_pkg::NUM_FDD; x++)
			m_eject[x] = next_hold(m_eject[x], host_i.fdd_eject[x] && !m_eject_q[x], EJECT_ONES);
		m_eject_q = host_i.fdd_eject;
		m_dl_q = ioctl_download_i;
		m_req_q = host_i.reset_req;
	endtask

	task automatic follow_loader();
		logic ack_rise;
		logic accept;
		ack_rise = ldr_ack_i && !m_ack_q;
		accept   = ioctl_wr_i && (m_state != x68k_ctrl_pkg::LDR_DONE);
		m_aen    = ioctl_download_i && (m_state != x68k_ctrl_pkg::LDR_DONE);
		if (m_state == x68k_ctrl_pkg::LDR_IDLE && accept)
			m_state = x68k_ctrl_pkg::LDR_WRITE;
		else if (m_state == x68k_ctrl_pkg::LDR_WRITE && ack_rise && !accept)
			m_state = x68k_ctrl_pkg::LDR_IDLE;
		if (m_ldl_q && !ioctl_download_i)
			m_state = x68k_ctrl_pkg::LDR_DONE;
		if (accept) begin
			m_req = ioctl_req_i;
			m_wr  = 1'b1;
		end else if (ack_rise) begin
			m_wr = 1'b0;
		end
		m_ack_q = ldr_ack_i;
		m_ldl_q = ioctl_download_i;
	endtask

	task automatic pipe_audio();
		exp_audio.left  = compress_sample(m_a1.left, m_mode1);
		exp_audio.right = compress_sample(m_a1.right, m_mode1);
		m_a1    = audio_i;
		m_mode1 = comp_mode_i;
	endtask

	always @(posedge clk_sys) begin
		if (reset_delayed) begin
			clear_models();
		end else begin
			predict_strobes();
			update_media_holds();
			follow_loader();
			pipe_audio();
		end
	end

	always @(negedge clk_sys) begin
		if (check_en) begin
			check_clk_en(exp_ce, clk_en_o);
			check_media(media_expect(), media_o);
			check_run(m_dl_seen && !m_reset_int, core_run_o);
			check_ldr(m_req, m_wr, m_aen, m_state == x68k_ctrl_pkg::LDR_DONE,
				ldr_req_o, ldr_wr_o, ldr_aen_o, ldr_done_o);
			check_audio(exp_audio, audio_o);
		end
	end

	always @(posedge clk_sys) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
			$display("Regression failed");
			$fatal(1);
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus

	function automatic x68k_audio_pkg::sample_t pick_sample();
		case ($urandom_range(0, 15))
			0: return 16'sd32767;
			1: return -16'sd32767;
			2: return 16'sh8000;
			3: return 16'(LIGHT_KNEE);
			4: return 16'(LIGHT_KNEE - 1);
			5: return 16'(-LIGHT_KNEE);
			6: return 16'(HEAVY_KNEE);
			7: return 16'(HEAVY_KNEE - 1);
			8: return 16'(-HEAVY_KNEE);
			default: return 16'($urandom);
		endcase
	endfunction

	// audio, mode, cpu speed and the core acknowledge run all the time
	always @(posedge clk_sys) begin
		audio_i <= '{left: pick_sample(), right: pick_sample()};
		if ($urandom_range(0, 7) == 0)
			comp_mode_i <= x68k_audio_pkg::comp_mode_t'(2'($urandom_range(0, 2)));
		if ($urandom_range(0, 15) == 0)
			h_turbo <= ~h_turbo;
		if ($urandom_range(0, 15) == 0)
			h_snd_slow <= ~h_snd_slow;
		// core acks a pending write after 0 to 6 cycles
		if (ldr_ack_i) begin
			ldr_ack_i <= 1'b0;
			ack_wait = $urandom_range(0, 6);
		end else if (ldr_wr_o) begin
			if (ack_wait == 0)
				ldr_ack_i <= 1'b1;
			else
				ack_wait = ack_wait - 1;
		end
	end

	task automatic apply_mounts();
		logic [x68k_ctrl_pkg::NUM_MEDIA-1:0] pulse;
		for (int i = 0; i < MOUNT_CYCLES; i++) begin
			@(posedge clk_sys);
			for (int x = 0; x < x68k_ctrl_pkg::NUM_MEDIA; x++)
				pulse[x] = ($urandom_range(0, 399) == 0);
			// floppy 0 mounted again while its hold is still running
			if (i == 20 || i == 150)
				pulse[0] = 1'b1;
			img_mounted_i <= pulse;
			if ($urandom_range(0, 31) == 0)
				h_fdd_eject <= h_fdd_eject ^ 2'(1 << $urandom_range(0, 1));
		end
		@(posedge clk_sys);
		img_mounted_i <= '0;
	endtask

	task automatic drive_download();
		@(posedge clk_sys);
		ioctl_download_i <= 1'b1;
		for (int i = 0; i < LOAD_CYCLES + DONE_CYCLES; i++) begin
			@(posedge clk_sys);
			ioctl_wr_i  <= ($urandom_range(0, 3) == 0);
			ioctl_req_i <= 28'($urandom);
			// download ends here and later writes go nowhere
			if (i == LOAD_CYCLES)
				ioctl_download_i <= 1'b0;
		end
		@(posedge clk_sys);
		ioctl_wr_i <= 1'b0;
	endtask

	task automatic exercise_resets();
		for (int i = 0; i < RSEQ_CYCLES; i++) begin
			@(posedge clk_sys);
			h_reset_req    <= ($urandom_range(0, 59) == 0);
			h_reset_button <= ($urandom_range(0, 99) == 0);
			// hard-disk mount in the middle of the sequence
			img_mounted_i  <= (i == 250) ? 4'b0100 : 4'b0000;
			if ($urandom_range(0, 23) == 0)
				h_fdd_eject <= h_fdd_eject ^ 2'(1 << $urandom_range(0, 1));
		end
		@(posedge clk_sys);
		h_reset_req    <= 1'b0;
		h_reset_button <= 1'b0;
		img_mounted_i  <= '0;
	endtask

	initial begin
		void'($urandom(SEED));
		repeat (RESET_CYCLES) @(posedge clk_sys);
		reset_delayed <= 1'b0;
		check_en      <= 1'b1;
		repeat (CLK_CYCLES) @(posedge clk_sys);
		apply_mounts();
		drive_download();
		exercise_resets();
		// compressor keeps going on the background stimulus
		repeat (AUDIO_CYCLES) @(posedge clk_sys);
		$display("Regression passed");
		$finish;
	end

endmodule

//--- src.f
x68k_ctrl_pkg.sv
x68k_audio_pkg.sv
clk_enable_gen.sv
media_reset_seq.sv
loader_fsm.sv
audio_compressor.sv
x68k_glue_top.sv
tb_x68k_glue.sv

//--- run.sh
#!/bin/sh
# build and run the glue logic regression with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_x68k_glue -f src.f -o tb_x68k_glue
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/tb_x68k_glue
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation failed with status $status"
	exit "$status"
fi

exit 0
